//--- hdl/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int index_bits  = 4;
    localparam int offset_bits = 5;
    localparam int tag_bits    = 23;
    localparam int line_bits   = 256;
    localparam int word_bits   = 32;

    // Address bits 31..9
    typedef logic [tag_bits-1:0] tag_t;

    typedef logic [line_bits-1:0] line_t;

    // Address bits 8..5
    typedef logic [index_bits-1:0] index_t;

    // Tree state per set
    // bit 0 is the root, 0 points at ways 0-1 and 1 at ways 2-3
    // bit 1 picks within ways 0-1, bit 2 within ways 2-3, 0 means the lower way
    typedef logic [2:0] plru_t;

    typedef logic [1:0] way_t;

    typedef enum logic [1:0] {
        idle_s,
        compare_s,
        fetch_s,
        reread_s
    } state_t;

endpackage

//--- hdl/icache_sram.sv
`timescale 1ns/1ps

module icache_sram
    import icache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     we,
    input  index_t   addr,
    input  payload_t din,
    output payload_t dout
);

    payload_t mem [num_sets];

    // Registered read returns the old entry on a same-edge write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

endmodule

//--- hdl/icache_ff_array.sv
`timescale 1ns/1ps

module icache_ff_array
    import icache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  index_t   addr,
    input  payload_t din,
    output payload_t dout
);

    payload_t mem [num_sets];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_sets; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                mem[addr] <= din;
            end
            // Same read timing as the SRAM model
            dout <= mem[addr];
        end
    end

endmodule

//--- hdl/icache_control.sv
`timescale 1ns/1ps

module icache_control
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   rmask,
    input  logic   hit,
    input  logic   dfp_resp,
    output state_t state,
    output logic   ufp_resp,
    output logic   dfp_read
);

    state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle_s;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            idle_s: begin
                // Arrays capture the index on this same edge
                if (rmask) begin
                    state_next = compare_s;
                end
            end
            compare_s: begin
                if (hit) begin
                    state_next = idle_s;
                end else begin
                    state_next = fetch_s;
                end
            end
            fetch_s: begin
                // Line, tag, valid and PLRU land at the dfp_resp edge
                if (dfp_resp) begin
                    state_next = reread_s;
                end
            end
            reread_s: begin
                // One cycle for the arrays to return the new line
                state_next = compare_s;
            end
            default: begin
                state_next = idle_s;
            end
        endcase
    end

    always_comb begin
        ufp_resp = 1'b0;
        dfp_read = 1'b0;
        unique case (state)
            compare_s: begin
                ufp_resp = hit;
            end
            fetch_s: begin
                dfp_read = 1'b1;
            end
            default: begin
                ufp_resp = 1'b0;
                dfp_read = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/icache_datapath.sv
`timescale 1ns/1ps

module icache_datapath
    import icache_pkg::*;
(
    input  state_t               state,
    input  logic                 dfp_resp,
    input  logic [31:0]          addr,
    input  logic                 ways_valid [num_ways],
    input  tag_t                 ways_tags [num_ways],
    input  line_t                ways_lines [num_ways],
    input  plru_t                plru,
    output logic                 hit,
    output logic [word_bits-1:0] rdata,
    output logic                 fill_we [num_ways],
    output logic                 plru_we,
    output plru_t                plru_next
);

    tag_t  addr_tag;
    logic  [2:0] word_sel;
    way_t  hit_way;
    way_t  victim;
    way_t  plru_way;
    way_t  access_way;
    logic  fill;
    line_t hit_line;

    assign addr_tag = addr[31:9];
    assign word_sel = addr[4:2];

    // Tag compare across all ways
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (ways_valid[i] && (ways_tags[i] == addr_tag)) begin
                hit = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

    assign hit_line = ways_lines[hit_way];
    assign rdata = hit_line[word_sel*word_bits +: word_bits];

    // Way the tree points at
    always_comb begin
        if (!plru[0]) begin
            plru_way = {1'b0, plru[1]};
        end else begin
            plru_way = {1'b1, plru[2]};
        end
    end

    // Lowest invalid way wins over the tree
    always_comb begin
        victim = plru_way;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (!ways_valid[i]) begin
                victim = way_t'(i);
            end
        end
    end

    assign fill = (state == fetch_s) && dfp_resp;

    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            fill_we[i] = fill && (victim == way_t'(i));
        end
    end

    assign access_way = fill ? victim : hit_way;
    assign plru_we = fill || ((state == compare_s) && hit);

    // Point the touched path away from the accessed way
    always_comb begin
        plru_next = plru;
        plru_next[0] = ~access_way[1];
        if (!access_way[1]) begin
            plru_next[1] = ~access_way[0];
        end else begin
            plru_next[2] = ~access_way[0];
        end
    end

endmodule

//--- hdl/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // CPU side
    input  logic [31:0]          ufp_addr,
    input  logic                 ufp_rmask,
    output logic [word_bits-1:0] ufp_rdata,
    output logic                 ufp_resp,

    // Memory side
    output logic [31:0]          dfp_addr,
    output logic                 dfp_read,
    input  line_t                dfp_rdata,
    input  logic                 dfp_resp
);

    tag_t   addr_tag;
    index_t addr_index;
    state_t state;
    logic   hit;

    logic  ways_valid [num_ways];
    tag_t  ways_tags [num_ways];
    line_t ways_lines [num_ways];
    logic  fill_we [num_ways];

    plru_t plru;
    plru_t plru_next;
    logic  plru_we;

    assign addr_tag   = ufp_addr[31:9];
    assign addr_index = ufp_addr[8:5];

    // Line-aligned fetch address
    assign dfp_addr = {ufp_addr[31:offset_bits], {offset_bits{1'b0}}};

    icache_control control_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rmask    (ufp_rmask),
        .hit      (hit),
        .dfp_resp (dfp_resp),
        .state    (state),
        .ufp_resp (ufp_resp),
        .dfp_read (dfp_read)
    );

    icache_datapath datapath_inst (
        .state      (state),
        .dfp_resp   (dfp_resp),
        .addr       (ufp_addr),
        .ways_valid (ways_valid),
        .ways_tags  (ways_tags),
        .ways_lines (ways_lines),
        .plru       (plru),
        .hit        (hit),
        .rdata      (ufp_rdata),
        .fill_we    (fill_we),
        .plru_we    (plru_we),
        .plru_next  (plru_next)
    );

    icache_ff_array #(.payload_t(plru_t)) plru_array (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (plru_we),
        .addr  (addr_index),
        .din   (plru_next),
        .dout  (plru)
    );

    for (genvar i = 0; i < num_ways; i++) begin : g_way
        icache_sram #(.payload_t(tag_t)) tag_array (
            .clk  (clk),
            .we   (fill_we[i]),
            .addr (addr_index),
            .din  (addr_tag),
            .dout (ways_tags[i])
        );

        icache_sram #(.payload_t(line_t)) line_array (
            .clk  (clk),
            .we   (fill_we[i]),
            .addr (addr_index),
            .din  (dfp_rdata),
            .dout (ways_lines[i])
        );

        // A fill always marks the way valid
        icache_ff_array #(.payload_t(logic)) valid_array (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (fill_we[i]),
            .addr  (addr_index),
            .din   (1'b1),
            .dout  (ways_valid[i])
        );
    end

endmodule

//--- dv/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] ufp_addr,
    input  logic        ufp_rmask,
    input  logic [31:0] ufp_rdata,
    input  logic        ufp_resp,
    input  logic [31:0] dfp_addr,
    input  logic        dfp_read,
    input  logic        dfp_resp,
    output int          error_count,
    output int          request_count,
    output int          miss_count
);

    // Reference state of the cache
    logic  valid_m [num_sets][num_ways];
    tag_t  tag_m [num_sets][num_ways];
    plru_t plru_m [num_sets];

    int          errors = 0;
    int          requests = 0;
    int          misses = 0;
    int          phase = 0;
    int          hit_way;
    int          victim_way;
    index_t      req_set;
    logic [31:0] req_addr;

    assign error_count   = errors;
    assign request_count = requests;
    assign miss_count    = misses;

    // Word rule of the backing memory
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'ha5a5_0000;
    endfunction

    function automatic int find_way(input logic [31:0] a);
        int way;
        way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_m[a[8:5]][w] && (tag_m[a[8:5]][w] == a[31:9])) begin
                way = w;
            end
        end
        return way;
    endfunction

    // Lowest invalid way first, then the tree
    function automatic int choose_victim(input index_t set);
        int way;
        if (!plru_m[set][0]) begin
            way = plru_m[set][1] ? 1 : 0;
        end else begin
            way = plru_m[set][2] ? 3 : 2;
        end
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_m[set][w]) begin
                way = w;
            end
        end
        return way;
    endfunction

    task automatic touch_way(input index_t set, input int way);
        plru_m[set][0] = (way < 2);
        if (way < 2) begin
            plru_m[set][1] = (way == 0);
        end else begin
            plru_m[set][2] = (way == 2);
        end
    endtask

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_rdata();
        if (ufp_rdata !== expected_word(req_addr)) begin
            log_error($sformatf("Fail ufp_rdata addr %h: got %h, expected %h",
                req_addr, ufp_rdata, expected_word(req_addr)));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                plru_m[s] = '0;
                for (int w = 0; w < num_ways; w++) begin
                    valid_m[s][w] = 1'b0;
                    tag_m[s][w] = '0;
                end
            end
            phase = 0;
        end else begin
            case (phase)
                0: begin
                    if (ufp_resp) begin
                        log_error($sformatf("ufp_resp high with no request at %0t", $time));
                    end
                    if (dfp_read) begin
                        log_error($sformatf("dfp_read high with no miss at %0t", $time));
                    end
                    if (ufp_rmask) begin
                        req_addr = ufp_addr;
                        req_set = ufp_addr[8:5];
                        hit_way = find_way(ufp_addr);
                        requests++;
                        phase = 1;
                    end
                end
                1: begin
                    if (dfp_read && hit_way >= 0) begin
                        log_error($sformatf("dfp_read raised on a hit at %0t", $time));
                    end
                    if (hit_way >= 0) begin
                        if (!ufp_resp) begin
                            log_error($sformatf("hit to %h not answered after one cycle",
                                req_addr));
                        end else begin
                            check_rdata();
                            touch_way(req_set, hit_way);
                        end
                        phase = 0;
                    end else begin
                        if (ufp_resp) begin
                            log_error($sformatf("ufp_resp for %h, expected a miss", req_addr));
                        end
                        misses++;
                        phase = 2;
                    end
                end
                2: begin
                    if (ufp_resp) begin
                        log_error($sformatf("ufp_resp during the fetch of %h", req_addr));
                    end
                    if (!dfp_read) begin
                        log_error($sformatf("dfp_read missing for the miss on %h", req_addr));
                        phase = 0;
                    end else if (dfp_resp) begin
                        if (dfp_addr !== {req_addr[31:5], 5'b0}) begin
                            log_error($sformatf("Fail dfp_addr: got %h, expected %h",
                                dfp_addr, {req_addr[31:5], 5'b0}));
                        end
                        victim_way = choose_victim(req_set);
                        valid_m[req_set][victim_way] = 1'b1;
                        tag_m[req_set][victim_way] = req_addr[31:9];
                        touch_way(req_set, victim_way);
                        phase = 3;
                    end
                end
                3: begin
                    if (ufp_resp || dfp_read) begin
                        log_error($sformatf("early ufp_resp or dfp_read after refill at %0t",
                            $time));
                    end
                    phase = 4;
                end
                default: begin
                    if (!ufp_resp) begin
                        log_error($sformatf("ufp_resp not two cycles after dfp_resp for %h",
                            req_addr));
                    end else begin
                        check_rdata();
                    end
                    phase = 0;
                end
            endcase
        end
    end

endmodule

//--- dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam logic [31:0] seed = 32'he20a583d;
    localparam int n_entries = 32;

    localparam logic [3:0] grp_cold    = 4'd0;
    localparam logic [3:0] grp_hit     = 4'd1;
    localparam logic [3:0] grp_victim  = 4'd2;
    localparam logic [3:0] grp_plru    = 4'd3;
    localparam logic [3:0] grp_reset   = 4'd4;
    localparam logic [3:0] grp_latency = 4'd5;

    typedef struct packed {
        logic [3:0]  group;
        logic [31:0] addr;
    } entry_t;

    // Index 3 holds five tags in the victim group, index 5 in the PLRU group
    localparam entry_t stim_tbl [n_entries] = '{
        '{grp_cold,    32'h0000_1000},
        '{grp_cold,    32'h0000_1024},
        '{grp_cold,    32'h0000_10fc},
        '{grp_cold,    32'h0002_3a48},
        '{grp_hit,     32'h0000_1004},
        '{grp_hit,     32'h0000_101c},
        '{grp_hit,     32'h0000_1020},
        '{grp_hit,     32'h0000_10e0},
        '{grp_hit,     32'h0002_3a40},
        '{grp_victim,  32'h0000_0260},
        '{grp_victim,  32'h0000_0460},
        '{grp_victim,  32'h0000_0660},
        '{grp_victim,  32'h0000_0860},
        '{grp_victim,  32'h0000_0a60},
        '{grp_victim,  32'h0000_0264},
        '{grp_plru,    32'h0000_02a0},
        '{grp_plru,    32'h0000_04a0},
        '{grp_plru,    32'h0000_06a0},
        '{grp_plru,    32'h0000_08a0},
        '{grp_plru,    32'h0000_02a4},
        '{grp_plru,    32'h0000_0aa0},
        '{grp_plru,    32'h0000_04a8},
        '{grp_plru,    32'h0000_06ac},
        '{grp_reset,   32'h0000_1000},
        '{grp_reset,   32'h0000_0a60},
        '{grp_reset,   32'h0000_1000},
        '{grp_latency, 32'h0001_0000},
        '{grp_latency, 32'h0001_0040},
        '{grp_latency, 32'h0001_0080},
        '{grp_latency, 32'h0001_00c8},
        '{grp_latency, 32'h0001_0100},
        '{grp_latency, 32'h0001_0184}
    };

    logic        clk;
    logic        rst_n;
    logic [31:0] ufp_addr;
    logic        ufp_rmask;
    logic [31:0] ufp_rdata;
    logic        ufp_resp;
    logic [31:0] dfp_addr;
    logic        dfp_read;
    line_t       dfp_rdata;
    logic        dfp_resp;

    int          error_count;
    int          request_count;
    int          miss_count;

    logic [31:0] mem_seed;
    logic [31:0] gap_seed;
    int          mem_wait;
    logic        mem_busy;

    icache icache_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    icache_checker checker_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .ufp_addr      (ufp_addr),
        .ufp_rmask     (ufp_rmask),
        .ufp_rdata     (ufp_rdata),
        .ufp_resp      (ufp_resp),
        .dfp_addr      (dfp_addr),
        .dfp_read      (dfp_read),
        .dfp_resp      (dfp_resp),
        .error_count   (error_count),
        .request_count (request_count),
        .miss_count    (miss_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Each word is its byte address xor a fixed pattern
    function automatic line_t build_line(input logic [31:0] a);
        line_t       line;
        logic [31:0] base;
        base = {a[31:5], 5'b0};
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = (base + i * 4) ^ 32'ha5a5_0000;
        end
        return line;
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic issue_request(input logic [31:0] addr);
        int gap;
        ufp_addr = addr;
        ufp_rmask = 1'b1;
        @(negedge clk);
        while (!ufp_resp) begin
            @(negedge clk);
        end
        // Response is taken at the rising edge in between
        @(negedge clk);
        ufp_rmask = 1'b0;
        gap_seed = lcg_next(gap_seed);
        gap = int'(gap_seed[29:28]);
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Backing memory with 1 to 8 cycles of delay
    initial begin
        dfp_resp = 1'b0;
        dfp_rdata = '0;
        mem_seed = seed;
        mem_busy = 1'b0;
        mem_wait = 0;
        forever begin
            @(negedge clk);
            dfp_resp = 1'b0;
            if (dfp_read && !mem_busy) begin
                mem_seed = lcg_next(mem_seed);
                mem_wait = 1 + int'(mem_seed[30:28]);
                mem_busy = 1'b1;
            end
            if (mem_busy) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    dfp_resp = 1'b1;
                    dfp_rdata = build_line(dfp_addr);
                    mem_busy = 1'b0;
                end
            end
        end
    end

    initial begin
        logic [3:0] prev_group;
        rst_n = 1'b0;
        ufp_addr = '0;
        ufp_rmask = 1'b0;
        gap_seed = seed;
        prev_group = grp_cold;
        @(negedge clk);
        apply_reset();
        // Quiet cycles with no request
        repeat (8) @(negedge clk);
        for (int i = 0; i < n_entries; i++) begin
            if (stim_tbl[i].group == grp_reset && prev_group != grp_reset) begin
                apply_reset();
            end
            issue_request(stim_tbl[i].addr);
            prev_group = stim_tbl[i].group;
        end
        repeat (4) @(negedge clk);
        if (request_count != n_entries) begin
            $display("Checker saw %0d requests but the table has %0d", request_count, n_entries);
        end
        $display("Requests %0d, misses %0d, errors %0d", request_count, miss_count, error_count);
        if (error_count == 0 && request_count == n_entries) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (n_entries * (8 + 3 + 4) + 200) @(posedge clk);
        $display("Timeout: the request table did not complete in time");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- icache.f
hdl/icache_pkg.sv
hdl/icache_sram.sv
hdl/icache_ff_array.sv
hdl/icache_control.sv
hdl/icache_datapath.sv
hdl/icache.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- run_icache.sh
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module icache_tb \
    -Mdir obj_dir \
    -f icache.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vicache_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$sim_output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
